// ==== isaPkg.sv ====
package isaPkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath width
	////////////////////////////////////////////////////////////////////////////

	// Fixed by the instruction set
	localparam int DATA_W = 16;

	////////////////////////////////////////////////////////////////////////////
	// Five-bit major opcode
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		// Special instructions
		HALT  = 5'b00000,
		NOP   = 5'b00001,
		SIIC  = 5'b00010,
		RTI   = 5'b00011,
		// Jumps, target is a plus b
		J     = 5'b00100,
		JR    = 5'b00101,
		JAL   = 5'b00110,
		JALR  = 5'b00111,
		// I-format arithmetic and logic
		SUBI  = 5'b01000,
		ADDI  = 5'b01001,
		ANDNI = 5'b01010,
		XORI  = 5'b01011,
		// Branches, condition tested on a
		BNEZ  = 5'b01100,
		BEQZ  = 5'b01101,
		BLTZ  = 5'b01110,
		BGEZ  = 5'b01111,
		// Memory and byte loads
		ST    = 5'b10000,
		LD    = 5'b10001,
		SLBI  = 5'b10010,
		STU   = 5'b10011,
		// Shift immediates, low two bits match shiftFunctE
		ROLI  = 5'b10100,
		SLLI  = 5'b10101,
		RORI  = 5'b10110,
		SRLI  = 5'b10111,
		// R-format groups
		LBI   = 5'b11000,
		BTR   = 5'b11001,
		ALU2  = 5'b11010,
		ALU1  = 5'b11011,
		// Set-compare group, 111xx
		SEQ   = 5'b11100,
		SLT   = 5'b11101,
		SLE   = 5'b11110,
		SCO   = 5'b11111
	} opcodeE;

	// Function field of ALU1
	typedef enum logic [1:0] {
		FN_ADD  = 2'b00,
		FN_SUB  = 2'b01,
		FN_XOR  = 2'b10,
		FN_ANDN = 2'b11
	} arithFunctE;

	// Function field of ALU2, also the barrel shifter mode
	typedef enum logic [1:0] {
		FN_ROL = 2'b00,
		FN_SLL = 2'b01,
		FN_ROR = 2'b10,
		FN_SRL = 2'b11
	} shiftFunctE;

endpackage

// ==== apbPkg.sv ====
package apbPkg;

	////////////////////////////////////////////////////////////////////////////
	// APB request and response
	////////////////////////////////////////////////////////////////////////////

	// Host to slave
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apbReqT;

	// Slave to host, pready tied high in this design
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apbRspT;

	////////////////////////////////////////////////////////////////////////////
	// Register map, low four address bits
	////////////////////////////////////////////////////////////////////////////

	localparam logic [3:0] REG_A      = 4'h0;
	localparam logic [3:0] REG_B      = 4'h4;
	// Opcode in 4:0, function field in 6:5
	localparam logic [3:0] REG_CTRL   = 4'h8;
	// Read-only status word
	localparam logic [3:0] REG_RESULT = 4'hC;

	// Result word, 20 bits, msb first
	typedef struct packed {
		logic                        taken;
		logic                        err;
		logic                        neg;
		logic                        zero;
		logic [isaPkg::DATA_W-1:0] result;
	} aluStatusT;

endpackage

// ==== barrelShifter.sv ====
`timescale 1ns/10ps

module barrelShifter (
	input  logic [isaPkg::DATA_W-1:0] in,
	input  logic [3:0]                cnt,
	input  isaPkg::shiftFunctE        mode,
	output logic [isaPkg::DATA_W-1:0] out
);

	localparam int W = isaPkg::DATA_W;

	////////////////////////////////////////////////////////////////////////////
	// Log shifter, stages of 1, 2, 4 and 8
	////////////////////////////////////////////////////////////////////////////

	always_comb begin : shiftStages
		logic [W-1:0] stage;
		int           sh;

		stage = in;
		// Count bit i enables the stage of width 2**i
		for (int i = 0; i < 4; i++) begin
			sh = 1 << i;
			if (cnt[i]) begin
				case (mode)
					// Bits leaving the top wrap to the bottom
					isaPkg::FN_ROL: stage = (stage << sh) | (stage >> (W - sh));
					// Zero fill from the right
					isaPkg::FN_SLL: stage = stage << sh;
					// Bits leaving the bottom wrap to the top
					isaPkg::FN_ROR: stage = (stage >> sh) | (stage << (W - sh));
					// Logical, zero fill from the left
					isaPkg::FN_SRL: stage = stage >> sh;
					default:        stage = stage;
				endcase
			end
		end
		out = stage;
	end

endmodule

// ==== branchCond.sv ====
`timescale 1ns/10ps

module branchCond (
	input  logic [isaPkg::DATA_W-1:0] a,
	input  isaPkg::opcodeE            op,
	output logic                      taken
);

	logic isBranch;
	logic aZero;
	logic aNeg;

	// Condition inputs, all taken from the first operand
	assign aZero = (a == '0);
	assign aNeg  = a[isaPkg::DATA_W-1];

	// The four I-format 2 branch codes
	assign isBranch = op inside {isaPkg::BNEZ, isaPkg::BEQZ, isaPkg::BLTZ, isaPkg::BGEZ};

	////////////////////////////////////////////////////////////////////////////
	// Condition select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (op)
			isaPkg::BNEZ: taken = !aZero;
			isaPkg::BEQZ: taken = aZero;
			// Signed compare against zero is just the sign bit
			isaPkg::BLTZ: taken = aNeg;
			isaPkg::BGEZ: taken = !aNeg;
			// Not a branch
			default:      taken = 1'b0;
		endcase
	end

	// Taken only ever reported for a branch
	always_comb begin
		assert final (!taken || isBranch)
			else $error("branchCond: taken high for opcode %s", op.name());
	end

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps

module alu (
	input  logic                      clk,
	input  logic [isaPkg::DATA_W-1:0] a,
	input  logic [isaPkg::DATA_W-1:0] b,
	input  isaPkg::opcodeE            op,
	input  logic [1:0]                funct,
	output logic [isaPkg::DATA_W-1:0] result,
	output logic                      zero,
	output logic                      neg,
	output logic                      err
);

	localparam int W = isaPkg::DATA_W;

	isaPkg::arithFunctE arithFn;
	isaPkg::shiftFunctE shiftMode;

	// Adder controls, derived from the opcode
	logic         invA;
	logic         cin;
	logic [W-1:0] aIn;
	// Carry out in the top bit
	logic [W:0]   sum;

	logic [W-1:0] shiftOut;
	logic [W-1:0] revA;
	logic         aLtB;

	////////////////////////////////////////////////////////////////////////////
	// Adder
	////////////////////////////////////////////////////////////////////////////

	assign arithFn = isaPkg::arithFunctE'(funct);

	// Subtract is b minus a, so invert a and add one
	assign invA = (op == isaPkg::SUBI) || (op == isaPkg::ALU1 && arithFn == isaPkg::FN_SUB);
	assign cin  = invA;
	assign aIn  = invA ? ~a : a;
	assign sum  = {1'b0, aIn} + {1'b0, b} + {{W{1'b0}}, cin};

	////////////////////////////////////////////////////////////////////////////
	// Shift, reverse, compare
	////////////////////////////////////////////////////////////////////////////

	// ALU2 takes its mode from funct, immediates from opcode bits 1:0
	assign shiftMode = (op == isaPkg::ALU2) ? isaPkg::shiftFunctE'(funct)
	                                        : isaPkg::shiftFunctE'(op[1:0]);

	// Count is the low nibble of b
	barrelShifter shifter (
		.in   (a),
		.cnt  (b[3:0]),
		.mode (shiftMode),
		.out  (shiftOut)
	);

	// BTR, bit i goes to bit W-1-i
	always_comb begin
		for (int i = 0; i < W; i++) begin
			revA[i] = a[W-1-i];
		end
	end

	// Signed less-than, shared by SLT and SLE
	assign aLtB = $signed(a) < $signed(b);

	////////////////////////////////////////////////////////////////////////////
	// Result select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		result = '0;
		err    = 1'b0;
		case (op)
			// No datapath result
			isaPkg::HALT, isaPkg::NOP, isaPkg::SIIC, isaPkg::RTI: result = '0;
			// Address sums and immediate add/subtract
			isaPkg::SUBI, isaPkg::ADDI,
			isaPkg::ST, isaPkg::LD, isaPkg::STU,
			isaPkg::J, isaPkg::JR, isaPkg::JAL, isaPkg::JALR,
			isaPkg::BNEZ, isaPkg::BEQZ, isaPkg::BLTZ, isaPkg::BGEZ: result = sum[W-1:0];
			isaPkg::XORI:  result = a ^ b;
			isaPkg::ANDNI: result = a & ~b;
			isaPkg::ALU1: begin
				case (arithFn)
					isaPkg::FN_XOR:  result = a ^ b;
					isaPkg::FN_ANDN: result = a & ~b;
					// Add and subtract both come off the adder
					default:         result = sum[W-1:0];
				endcase
			end
			// Register and immediate shifts
			isaPkg::ROLI, isaPkg::SLLI, isaPkg::RORI, isaPkg::SRLI,
			isaPkg::ALU2:  result = shiftOut;
			isaPkg::BTR:   result = revA;
			isaPkg::LBI:   result = b;
			// Low byte of b appended under a
			isaPkg::SLBI:  result = (a << 8) | {{(W-8){1'b0}}, b[7:0]};
			// Set-compare, single bit result
			isaPkg::SEQ:   result = {{(W-1){1'b0}}, a == b};
			isaPkg::SLT:   result = {{(W-1){1'b0}}, aLtB};
			isaPkg::SLE:   result = {{(W-1){1'b0}}, aLtB || (a == b)};
			// Carry of a plus b, invA is low here
			isaPkg::SCO:   result = {{(W-1){1'b0}}, sum[W]};
			// Unknown code
			default:       err = 1'b1;
		endcase
	end

	// Flags follow the selected result
	assign zero = (result == '0);
	assign neg  = result[W-1];

	// Error always comes with a cleared result and zero flag
	assert property (@(posedge clk) err |-> (result == '0) && zero)
		else $error("alu: err with nonzero result %h", result);

endmodule

// ==== aluRegs.sv ====
`timescale 1ns/10ps

module aluRegs #(
	parameter int APB_ADDR_W = 8
) (
	input  logic                      clk,
	input  logic                      rstN,
	input  apbPkg::apbReqT            req,
	output apbPkg::apbRspT            rsp,
	output logic [isaPkg::DATA_W-1:0] a,
	output logic [isaPkg::DATA_W-1:0] b,
	output isaPkg::opcodeE            op,
	output logic [1:0]                funct,
	input  apbPkg::aluStatusT         status
);

	// Address decode
	logic [APB_ADDR_W-1:0] addr;
	logic [3:0]            offset;
	logic                  access;
	logic                  inRange;
	logic                  aligned;
	logic                  selA;
	logic                  selB;
	logic                  selCtrl;
	logic                  selResult;
	logic                  slvErr;
	logic                  wrEn;
	logic                  ctrlWr;

	// Register file
	logic [isaPkg::DATA_W-1:0] aReg;
	logic [isaPkg::DATA_W-1:0] bReg;
	logic [6:0]                ctrlReg;
	apbPkg::aluStatusT         resultReg;
	logic [31:0]               rdData;

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	assign addr   = req.paddr[APB_ADDR_W-1:0];
	assign offset = addr[3:0];
	// Second cycle of the transfer
	assign access = req.psel && req.penable;

	// Anything above the four registers is out of the map
	assign inRange = (addr >> 4) == '0;
	assign aligned = (addr[1:0] == 2'b00);

	assign selA      = inRange && (offset == apbPkg::REG_A);
	assign selB      = inRange && (offset == apbPkg::REG_B);
	assign selCtrl   = inRange && (offset == apbPkg::REG_CTRL);
	assign selResult = inRange && (offset == apbPkg::REG_RESULT);

	// Unmapped, unaligned, or write to the read-only result
	assign slvErr = access && (!aligned || !(selA || selB || selCtrl || selResult) ||
	                           (req.pwrite && selResult));

	assign wrEn   = access && req.pwrite && !slvErr;
	assign ctrlWr = wrEn && selCtrl;

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			aReg      <= '0;
			bReg      <= '0;
			ctrlReg   <= '0;
			resultReg <= '0;
		end else begin
			if (wrEn && selA) aReg <= req.pwdata[isaPkg::DATA_W-1:0];
			if (wrEn && selB) bReg <= req.pwdata[isaPkg::DATA_W-1:0];
			// Control write also latches the ALU outputs
			if (ctrlWr) begin
				ctrlReg   <= req.pwdata[6:0];
				resultReg <= status;
			end
		end
	end

	assign a = aReg;
	assign b = bReg;

	// New control word reaches the ALU during its own write access
	always_comb begin
		if (ctrlWr) begin
			op    = isaPkg::opcodeE'(req.pwdata[4:0]);
			funct = req.pwdata[6:5];
		end else begin
			op    = isaPkg::opcodeE'(ctrlReg[4:0]);
			funct = ctrlReg[6:5];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read data and response
	////////////////////////////////////////////////////////////////////////////

	// Zero-extended, zero outside a clean read access
	always_comb begin
		rdData = '0;
		if (access && !req.pwrite && !slvErr) begin
			if (selA)           rdData = 32'(aReg);
			else if (selB)      rdData = 32'(bReg);
			else if (selCtrl)   rdData = 32'(ctrlReg);
			else if (selResult) rdData = 32'(resultReg);
		end
	end

	// No wait states
	assign rsp = '{prdata: rdData, pready: 1'b1, pslverr: slvErr};

	assert property (@(posedge clk) disable iff (!rstN) rsp.pready)
		else $error("aluRegs: pready low");

	assert property (@(posedge clk) disable iff (!rstN)
		rsp.pslverr |-> req.psel && req.penable)
		else $error("aluRegs: pslverr outside an access cycle");

endmodule

// ==== aluTop.sv ====
`timescale 1ns/10ps

module aluTop (
	input  logic           clk,
	input  logic           rstN,
	input  apbPkg::apbReqT req,
	output apbPkg::apbRspT rsp
);

	// Operands and control from the register block
	logic [isaPkg::DATA_W-1:0] opA;
	logic [isaPkg::DATA_W-1:0] opB;
	isaPkg::opcodeE            op;
	logic [1:0]                funct;

	// Execute outputs
	logic [isaPkg::DATA_W-1:0] result;
	logic                      zero;
	logic                      neg;
	logic                      err;
	logic                      taken;
	apbPkg::aluStatusT         status;

	////////////////////////////////////////////////////////////////////////////
	// APB slave
	////////////////////////////////////////////////////////////////////////////

	aluRegs #(
		.APB_ADDR_W (8)
	) regs (
		.clk    (clk),
		.rstN   (rstN),
		.req    (req),
		.rsp    (rsp),
		.a      (opA),
		.b      (opB),
		.op     (op),
		.funct  (funct),
		.status (status)
	);

	////////////////////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////////////////////

	alu exec (
		.clk    (clk),
		.a      (opA),
		.b      (opB),
		.op     (op),
		.funct  (funct),
		.result (result),
		.zero   (zero),
		.neg    (neg),
		.err    (err)
	);

	// Branch test on operand A only
	branchCond branch (
		.a     (opA),
		.op    (op),
		.taken (taken)
	);

	// Packed into the result word layout
	assign status = '{taken: taken, err: err, neg: neg, zero: zero, result: result};

endmodule

// ==== aluTbModel.svh ====
`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

// One single-bit step per count, fill is zero for shifts
function automatic logic [15:0] shiftModel(input logic [15:0] v, input logic [3:0] n,
	input logic [1:0] mode);
	logic [15:0] s;
	s = v;
	for (int k = 0; k < int'(n); k++) begin
		case (mode)
			isaPkg::FN_ROL: s = {s[14:0], s[15]};
			isaPkg::FN_SLL: s = {s[14:0], 1'b0};
			isaPkg::FN_ROR: s = {s[0], s[15:1]};
			default:        s = {1'b0, s[15:1]};
		endcase
	end
	return s;
endfunction

// Expected status word for one operation
function automatic logic [19:0] modelStatus(input logic [15:0] a, input logic [15:0] b,
	input logic [4:0] op, input logic [1:0] funct);
	apbPkg::aluStatusT st;
	logic [16:0]       wide;
	logic              sLt;
	st   = '0;
	wide = {1'b0, a} + {1'b0, b};
	// Signs differ, so the negative one is smaller
	sLt  = (a[15] != b[15]) ? a[15] : (a < b);
	case (op)
		isaPkg::HALT, isaPkg::NOP, isaPkg::SIIC, isaPkg::RTI: st.result = '0;
		isaPkg::J, isaPkg::JR, isaPkg::JAL, isaPkg::JALR, isaPkg::ADDI,
		isaPkg::ST, isaPkg::LD, isaPkg::STU,
		isaPkg::BNEZ, isaPkg::BEQZ, isaPkg::BLTZ, isaPkg::BGEZ: st.result = wide[15:0];
		isaPkg::SUBI:  st.result = b - a;
		isaPkg::XORI:  st.result = a ^ b;
		isaPkg::ANDNI: st.result = a & ~b;
		isaPkg::ALU1: begin
			case (funct)
				isaPkg::FN_ADD: st.result = a + b;
				isaPkg::FN_SUB: st.result = b - a;
				isaPkg::FN_XOR: st.result = a ^ b;
				default:        st.result = a & ~b;
			endcase
		end
		isaPkg::ROLI:  st.result = shiftModel(a, b[3:0], isaPkg::FN_ROL);
		isaPkg::SLLI:  st.result = shiftModel(a, b[3:0], isaPkg::FN_SLL);
		isaPkg::RORI:  st.result = shiftModel(a, b[3:0], isaPkg::FN_ROR);
		isaPkg::SRLI:  st.result = shiftModel(a, b[3:0], isaPkg::FN_SRL);
		isaPkg::ALU2:  st.result = shiftModel(a, b[3:0], funct);
		isaPkg::BTR: begin
			for (int i = 0; i < 16; i++) begin
				st.result[i] = a[15-i];
			end
		end
		isaPkg::LBI:   st.result = b;
		isaPkg::SLBI:  st.result = {a[7:0], b[7:0]};
		isaPkg::SEQ:   st.result = 16'(a == b);
		isaPkg::SLT:   st.result = 16'(sLt);
		isaPkg::SLE:   st.result = 16'(sLt || (a == b));
		isaPkg::SCO:   st.result = 16'(wide[16]);
		default:       st.err = 1'b1;
	endcase
	st.zero = (st.result == 16'h0000);
	st.neg  = st.result[15];
	// Branch conditions look at a alone
	case (op)
		isaPkg::BNEZ: st.taken = (a != 16'h0000);
		isaPkg::BEQZ: st.taken = (a == 16'h0000);
		isaPkg::BLTZ: st.taken = a[15];
		isaPkg::BGEZ: st.taken = !a[15];
		default:      st.taken = 1'b0;
	endcase
	return st;
endfunction

`endif

// ==== aluTb.sv ====
`timescale 1ns/10ps

module aluTb;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_OPS   = 350;
	localparam int SHIFT_OPS    = 50;
	// Reset reads, random, directed, branch, opcode sweep, bus errors
	localparam int NUM_TXN = 4 + RANDOM_OPS + SHIFT_OPS + 10 + 16 + 32 + 4;
	// Four APB transfers of three cycles each
	localparam int CYCLES_PER_TXN = 12;
	localparam longint TIMEOUT_NS =
		longint'(NUM_TXN * CYCLES_PER_TXN + RESET_CYCLES) * CLK_PERIOD * 4;

	localparam logic [4:0] SHIFT_CODES [5] = '{isaPkg::ROLI, isaPkg::SLLI, isaPkg::RORI,
		isaPkg::SRLI, isaPkg::ALU2};
	localparam logic [4:0] BRANCH_CODES [4] = '{isaPkg::BNEZ, isaPkg::BEQZ, isaPkg::BLTZ,
		isaPkg::BGEZ};
	localparam logic [15:0] BRANCH_VALUES [4] = '{16'h0000, 16'h8000, 16'h0001, 16'hFFFF};

	logic           clk;
	logic           rstN;
	apbPkg::apbReqT req;
	apbPkg::apbRspT rsp;
	logic [31:0]    lcgState;

	`include "aluTbModel.svh"

	aluTop dut_i (
		.clk  (clk),
		.rstN (rstN),
		.req  (req),
		.rsp  (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Numerical Recipes constants
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic checkEq(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (actVal !== expVal) begin
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
			$display("Done: errors found");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// Setup, access, then idle, each on a falling edge
	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data,
		output logic slvErr);
		@(negedge clk);
		req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(negedge clk);
		req.penable = 1'b1;
		// Mid low phase, responses settled
		#2;
		checkEq("pready", 1, rsp.pready);
		slvErr = rsp.pslverr;
		@(negedge clk);
		req = '0;
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data,
		output logic slvErr);
		@(negedge clk);
		req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
		@(negedge clk);
		req.penable = 1'b1;
		#2;
		checkEq("pready", 1, rsp.pready);
		data   = rsp.prdata;
		slvErr = rsp.pslverr;
		@(negedge clk);
		req = '0;
	endtask

	// Data only compared on a clean read
	task automatic readExpect(input logic [7:0] addr, input logic [31:0] expData,
		input logic expErr, input string name);
		logic [31:0] rd;
		logic        slvErr;
		apbRead(addr, rd, slvErr);
		checkEq({name, " pslverr"}, expErr, slvErr);
		if (!expErr) checkEq(name, expData, rd);
	endtask

	// Write A, B and CTRL, then read back the status word
	task automatic runOp(input logic [15:0] a, input logic [15:0] b, input logic [4:0] op,
		input logic [1:0] funct);
		apbPkg::aluStatusT expS;
		apbPkg::aluStatusT gotS;
		logic [31:0]       rd;
		logic              slvErr;
		expS = modelStatus(a, b, op, funct);
		apbWrite({4'h0, apbPkg::REG_A}, {16'h0, a}, slvErr);
		checkEq("pslverr on A write", 0, slvErr);
		apbWrite({4'h0, apbPkg::REG_B}, {16'h0, b}, slvErr);
		checkEq("pslverr on B write", 0, slvErr);
		apbWrite({4'h0, apbPkg::REG_CTRL}, {25'h0, funct, op}, slvErr);
		checkEq("pslverr on CTRL write", 0, slvErr);
		apbRead({4'h0, apbPkg::REG_RESULT}, rd, slvErr);
		checkEq("pslverr on RESULT read", 0, slvErr);
		gotS = rd[19:0];
		checkEq("prdata upper bits", 0, rd[31:20]);
		checkEq("result", expS.result, gotS.result);
		checkEq("zero", expS.zero, gotS.zero);
		checkEq("neg", expS.neg, gotS.neg);
		checkEq("err", expS.err, gotS.err);
		checkEq("taken", expS.taken, gotS.taken);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [31:0] prevResult;
		logic        slvErr;
		req      = '0;
		rstN     = 1'b0;
		lcgState = 32'h4aeb_c780;
		repeat (RESET_CYCLES) @(negedge clk);
		rstN = 1'b1;

		// Everything clear out of reset
		readExpect({4'h0, apbPkg::REG_RESULT}, 0, 1'b0, "reset RESULT");
		readExpect({4'h0, apbPkg::REG_A}, 0, 1'b0, "reset A");
		readExpect({4'h0, apbPkg::REG_B}, 0, 1'b0, "reset B");
		readExpect({4'h0, apbPkg::REG_CTRL}, 0, 1'b0, "reset CTRL");

		// Any opcode, any function field
		for (int i = 0; i < RANDOM_OPS; i++) begin
			r1 = nextRand();
			r2 = nextRand();
			r3 = nextRand();
			runOp(r1[31:16], r2[31:16], r3[28:24], r3[30:29]);
		end

		// Shift group, count sweeps 0 to 15
		for (int i = 0; i < SHIFT_OPS; i++) begin
			r1 = nextRand();
			r2 = nextRand();
			r3 = nextRand();
			runOp(r1[31:16], {r2[31:20], 4'(i)}, SHIFT_CODES[r3[31:16] % 5], r3[30:29]);
		end

		// Compare and carry corners
		runOp(16'h1234, 16'h1234, isaPkg::SEQ, 2'b00);
		runOp(16'h8000, 16'h7FFF, isaPkg::SLT, 2'b00);
		runOp(16'h7FFF, 16'h8000, isaPkg::SLT, 2'b00);
		runOp(16'h8000, 16'h8000, isaPkg::SLE, 2'b00);
		runOp(16'h7FFF, 16'h8000, isaPkg::SLE, 2'b00);
		runOp(16'h8000, 16'h7FFF, isaPkg::SLE, 2'b00);
		runOp(16'hFFFF, 16'h0001, isaPkg::SCO, 2'b00);
		runOp(16'h7FFF, 16'h0001, isaPkg::SCO, 2'b00);
		runOp(16'h5555, 16'h5555, isaPkg::SUBI, 2'b00);
		runOp(16'hA5A5, 16'hA5A5, isaPkg::ALU1, isaPkg::FN_SUB);

		// Each branch against zero, sign bit, one, all ones
		foreach (BRANCH_CODES[i]) begin
			foreach (BRANCH_VALUES[j]) begin
				r2 = nextRand();
				runOp(BRANCH_VALUES[j], r2[31:16], BRANCH_CODES[i], 2'b00);
			end
		end

		// Full opcode sweep, specials and unknowns included
		for (int i = 0; i < 32; i++) begin
			r1 = nextRand();
			r2 = nextRand();
			runOp(r1[31:16], r2[31:16], 5'(i), r2[1:0]);
		end

		// Known status before the bus errors
		runOp(16'h1234, 16'h0F0F, isaPkg::ADDI, 2'b00);
		prevResult = {12'h000, modelStatus(16'h1234, 16'h0F0F, isaPkg::ADDI, 2'b00)};
		readExpect(8'h10, 0, 1'b1, "read of offset 0x10");
		apbWrite(8'h10, 32'hDEAD_BEEF, slvErr);
		checkEq("pslverr on write to 0x10", 1, slvErr);
		apbWrite({4'h0, apbPkg::REG_RESULT}, 32'hFFFF_FFFF, slvErr);
		checkEq("pslverr on RESULT write", 1, slvErr);
		readExpect(8'h02, 0, 1'b1, "unaligned read");
		// Misaligned CTRL write must not relatch status
		apbWrite(8'h09, {25'h0, 2'b00, isaPkg::SUBI}, slvErr);
		checkEq("pslverr on unaligned write", 1, slvErr);
		readExpect({4'h0, apbPkg::REG_RESULT}, prevResult, 1'b0, "RESULT after bus errors");

		$display("Done: no errors");
		$finish;
	end

	// Generous bound on the whole run
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== vlog.f ====
+incdir+.
isaPkg.sv
apbPkg.sv
barrelShifter.sv
branchCond.sv
alu.sv
aluRegs.sv
aluTop.sv
aluTb.sv

// ==== Bender.yml ====
package:
  name: aluApb

sources:
  - files:
      - isaPkg.sv
      - apbPkg.sv
      - barrelShifter.sv
      - branchCond.sv
      - alu.sv
      - aluRegs.sv
      - aluTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - aluTb.sv
